// ==== include/sbk_defaults.svh ====
/*
 * Default region start offsets in bytes for the basketball map.
 * Other games override them through the top level parameters.
 */
`ifndef SBK_DEFAULTS_SVH
`define SBK_DEFAULTS_SVH

// Main CPU code sits at zero, 64 kB
`define SBK_SND_START  25'h01_0000
// Sound CPU code, 8 kB
`define SBK_SCR_START  25'h01_2000
// Scroll tiles up to the PCM samples
`define SBK_PCM_START  25'h01_A000
// Colour PROMs, kept out of SDRAM
`define SBK_PROM_START 25'h02_2000

`endif

// ==== design/sbk_mem_pkg.sv ====
/*
 * Memory map types shared by the download and fetch sides.
 * Region order follows the SDRAM layout: main, sound, scroll tiles, PCM,
 * then colour PROMs, which never reach SDRAM.
 * Slot order is also the fetch priority, so scr (0) wins over main (2).
 */
`default_nettype none

package sbk_mem_pkg;

    // SDRAM is addressed in 16-bit words
    parameter int SDRAM_AW = 22;

    // Loader byte address
    parameter int IOCTL_AW = 25;

    // Address width of every ROM slot
    parameter int SLOT_AW = 16;

    // Local address of the colour PROM write port
    parameter int PROM_AW = 11;

    // Where a download byte lands
    typedef enum logic [2:0] {
        REG_MAIN = 3'd0,
        REG_SND  = 3'd1,
        REG_SCR  = 3'd2,
        REG_PCM  = 3'd3,
        REG_PROM = 3'd4
    } region_e;

    // Slot identity, value doubles as priority (lower wins)
    typedef enum logic [1:0] {
        SLOT_SCR  = 2'd0,
        SLOT_SND  = 2'd1,
        SLOT_MAIN = 2'd2
    } slot_e;

    // Number of slots served by the arbiter
    parameter int NUM_SLOTS = 3;

endpackage

`default_nettype wire

// ==== design/sbk_bus_pkg.sv ====
/*
 * Bus level records between the ROM subsystem and the SDRAM controller.
 * prog_wr_t carries one byte; the controller replicates it on both lanes
 * and the active-low mask picks the lane that is really written.
 */
`default_nettype none

package sbk_bus_pkg;

    // One SDRAM program write, 33 bits
    typedef struct packed {
        logic [sbk_mem_pkg::SDRAM_AW-1:0] addr;
        logic [7:0]                       data;
        // Active low, bit of the unused byte is high
        logic [1:0]                       mask;
        logic                             we;
    } prog_wr_t;

    // Request from one ROM client
    typedef struct packed {
        logic                            cs;
        logic [sbk_mem_pkg::SLOT_AW-1:0] addr;
    } slot_req_t;

    // Byte view of an SDRAM word
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } byte_pair_t;

    // SDRAM read word
    // 8-bit slots pick one byte, the 32-bit slot takes it as one half
    typedef union packed {
        byte_pair_t  bytes;
        logic [15:0] half;
    } sdram_word_u;

endpackage

`default_nettype wire

// ==== design/sbk_dwnld_decode.sv ====
/*
 * Loader byte stream to SDRAM program writes and PROM strobes.
 * The loader must wait for sdram_ack before sending the next byte.
 * PROM bytes get a single-cycle prom_we and never wait for an ack.
 * Region bounds must satisfy SCR_START <= PCM_START <= PROM_START.
 */
`timescale 1ns/10ps
`default_nettype none

module sbk_dwnld_decode #(
    parameter logic [sbk_mem_pkg::IOCTL_AW-1:0] SCR_START  = '0,
    parameter logic [sbk_mem_pkg::IOCTL_AW-1:0] PCM_START  = '0,
    parameter logic [sbk_mem_pkg::IOCTL_AW-1:0] PROM_START = '0
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              downloading,
    input  logic [sbk_mem_pkg::IOCTL_AW-1:0]  ioctl_addr,
    input  logic [7:0]                        ioctl_dout,
    input  logic                              ioctl_wr,
    input  logic                              sdram_ack,
    output sbk_bus_pkg::prog_wr_t             prog,
    output logic                              prom_we,
    output logic [sbk_mem_pkg::PROM_AW-1:0]   prom_addr
);
    import sbk_mem_pkg::*;

    region_e               region;
    logic                  accept;
    logic [IOCTL_AW-1:0]   prom_ofs;
    logic                  we_q;
    logic [SDRAM_AW-1:0]   addr_q;
    logic [7:0]            data_q;
    logic [1:0]            mask_q;

    // Main and sound code are both stored as plain bytes, so no
    // split below SCR_START is needed here
    always_comb begin
        if (ioctl_addr >= PROM_START) begin
            region = REG_PROM;
        end else if (ioctl_addr >= PCM_START) begin
            region = REG_PCM;
        end else if (ioctl_addr >= SCR_START) begin
            region = REG_SCR;
        end else begin
            region = REG_MAIN;
        end
    end

    assign accept   = ioctl_wr && downloading;
    assign prom_ofs = ioctl_addr - PROM_START;

    // Write strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            we_q    <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= 1'b0;
            if (accept && region == REG_PROM) begin
                prom_we <= 1'b1;
            end else if (accept) begin
                we_q <= 1'b1;
            end else if (sdram_ack) begin
                we_q <= 1'b0;
            end
        end
    end

    // Payload, stable while we_q is high as the loader waits for the ack
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q    <= SDRAM_AW'(ioctl_addr >> 1);
            // Odd byte goes to the high lane
            mask_q    <= {~ioctl_addr[0], ioctl_addr[0]};
            prom_addr <= prom_ofs[PROM_AW-1:0];
            if (region == REG_SCR) begin
                // Tile data is stored nibble swapped
                data_q <= {ioctl_dout[3:0], ioctl_dout[7:4]};
            end else begin
                data_q <= ioctl_dout;
            end
        end
    end

    // PROM data also leaves on prog.data
    assign prog = '{addr: addr_q, data: data_q, mask: mask_q, we: we_q};

endmodule

`default_nettype wire

// ==== design/sbk_slot_arbiter.sv ====
/*
 * Fixed priority fetch scheduler for the three ROM slots.
 * One SDRAM access in flight at a time; priority is scr, snd, main.
 * hit is registered, so ok follows cs and address changes by one cycle.
 * Any download drops the request and invalidates every slot cache.
 */
`timescale 1ns/10ps
`default_nettype none

module sbk_slot_arbiter #(
    parameter logic [sbk_mem_pkg::IOCTL_AW-1:0] SND_START = '0,
    parameter logic [sbk_mem_pkg::IOCTL_AW-1:0] SCR_START = '0
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              downloading,
    input  sbk_bus_pkg::slot_req_t            scr_req,
    input  sbk_bus_pkg::slot_req_t            snd_req,
    input  sbk_bus_pkg::slot_req_t            main_req,
    input  logic                              done,
    input  logic                              sdram_ack,
    output logic                              sdram_req,
    output logic [sbk_mem_pkg::SDRAM_AW-1:0]  sdram_addr,
    output sbk_mem_pkg::slot_e                sel,
    output logic                              start,
    output logic                              byte_hi,
    output logic [2:0]                        hit
);
    import sbk_mem_pkg::*;
    import sbk_bus_pkg::*;

    // Word offsets of the regions
    localparam logic [SDRAM_AW-1:0] SND_OFS = SDRAM_AW'(SND_START >> 1);
    localparam logic [SDRAM_AW-1:0] SCR_OFS = SDRAM_AW'(SCR_START >> 1);

    slot_req_t [NUM_SLOTS-1:0]              req;
    logic [NUM_SLOTS-1:0][SLOT_AW-1:0]      last_addr;
    logic [NUM_SLOTS-1:0]                   valid;
    logic [NUM_SLOTS-1:0]                   cs;
    logic [NUM_SLOTS-1:0]                   match;
    logic [NUM_SLOTS-1:0]                   need;
    logic [NUM_SLOTS-1:0]                   hit_q;
    logic                                   busy;
    logic                                   req_q;
    logic                                   launch;
    slot_e                                  pick;
    logic [SDRAM_AW-1:0]                    pick_addr;

    // Index by slot_e value
    assign req = {main_req, snd_req, scr_req};

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            cs[i]    = req[i].cs;
            match[i] = last_addr[i] == req[i].addr;
            need[i]  = cs[i] && !(valid[i] && match[i]);
        end
    end

    // Highest priority missing slot and its SDRAM word
    always_comb begin
        if (need[SLOT_SCR]) begin
            pick = SLOT_SCR;
        end else if (need[SLOT_SND]) begin
            pick = SLOT_SND;
        end else begin
            pick = SLOT_MAIN;
        end
        case (pick)
            // Two words per 32-bit entry, low half first
            SLOT_SCR: pick_addr = SCR_OFS + SDRAM_AW'({req[SLOT_SCR].addr, 1'b0});
            SLOT_SND: pick_addr = SND_OFS + SDRAM_AW'(req[SLOT_SND].addr >> 1);
            default:  pick_addr = SDRAM_AW'(req[SLOT_MAIN].addr >> 1);
        endcase
    end

    assign launch = !busy && !downloading && |need;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            req_q <= 1'b0;
            start <= 1'b0;
            valid <= '0;
            hit_q <= '0;
            sel   <= SLOT_SCR;
        end else begin
            start <= launch;
            // A hit is seen only once cs has been sampled
            hit_q <= valid & match & cs;
            if (downloading) begin
                // SDRAM contents are being rewritten
                busy  <= 1'b0;
                req_q <= 1'b0;
                valid <= '0;
            end else if (launch) begin
                busy        <= 1'b1;
                req_q       <= 1'b1;
                sel         <= pick;
                valid[pick] <= 1'b0;
            end else if (busy) begin
                if (sdram_ack) begin
                    req_q <= 1'b0;
                end
                if (done) begin
                    busy       <= 1'b0;
                    valid[sel] <= 1'b1;
                end
            end
        end
    end

    // Fetch address and byte lane, held for the whole access
    always_ff @(posedge clk) begin
        if (launch) begin
            last_addr[pick] <= req[pick].addr;
            sdram_addr      <= pick_addr;
            byte_hi         <= req[pick].addr[0];
        end
    end

    assign sdram_req = req_q && !downloading;
    assign hit       = hit_q & {NUM_SLOTS{~downloading}};

endmodule

`default_nettype wire

// ==== design/sbk_slot_return.sv ====
/*
 * Steers SDRAM read words into the slot data registers.
 * The 32-bit slot expects two words, low half first; 8-bit slots one word.
 * data_rdy must come with the last data_dst of an access.
 */
`timescale 1ns/10ps
`default_nettype none

module sbk_slot_return (
    input  logic                     clk,
    input  logic                     reset,
    input  sbk_mem_pkg::slot_e       sel,
    input  logic                     start,
    input  logic                     byte_hi,
    input  logic [2:0]               hit,
    input  logic [2:0]               cs,
    input  sbk_bus_pkg::sdram_word_u data_read,
    input  logic                     data_dst,
    input  logic                     data_rdy,
    output logic [31:0]              scr_dout,
    output logic [7:0]               snd_dout,
    output logic [7:0]               main_dout,
    output logic [2:0]               ok,
    output logic                     done
);
    import sbk_mem_pkg::*;

    logic active;
    logic upper;
    logic capture;

    assign capture = active && data_dst;

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            upper  <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= active && data_rdy;
            if (start) begin
                active <= 1'b1;
                upper  <= 1'b0;
            end else if (capture) begin
                // Next word of a 32-bit access is the high half
                upper <= 1'b1;
                if (data_rdy) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            case (sel)
                SLOT_SCR: begin
                    if (upper) begin
                        scr_dout[31:16] <= data_read.half;
                    end else begin
                        scr_dout[15:0] <= data_read.half;
                    end
                end
                SLOT_SND: begin
                    snd_dout <= byte_hi ? data_read.bytes.hi : data_read.bytes.lo;
                end
                default: begin
                    main_dout <= byte_hi ? data_read.bytes.hi : data_read.bytes.lo;
                end
            endcase
        end
    end

    // Slot data valid only for a requesting client
    assign ok = hit & cs;

endmodule

`default_nettype wire

// ==== design/sbk_rom_top.sv ====
/*
 * ROM download and fetch subsystem of the arcade core.
 * Region offsets default to the basketball map; other games override them.
 * All clients share clk; no clock enables are handled here.
 */
`timescale 1ns/10ps
`default_nettype none

`include "sbk_defaults.svh"

module sbk_rom_top #(
    parameter logic [sbk_mem_pkg::IOCTL_AW-1:0] SND_START  = `SBK_SND_START,
    parameter logic [sbk_mem_pkg::IOCTL_AW-1:0] SCR_START  = `SBK_SCR_START,
    parameter logic [sbk_mem_pkg::IOCTL_AW-1:0] PCM_START  = `SBK_PCM_START,
    parameter logic [sbk_mem_pkg::IOCTL_AW-1:0] PROM_START = `SBK_PROM_START
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              downloading,
    // Loader
    input  logic [sbk_mem_pkg::IOCTL_AW-1:0]  ioctl_addr,
    input  logic [7:0]                        ioctl_dout,
    input  logic                              ioctl_wr,
    output sbk_bus_pkg::prog_wr_t             prog,
    output logic                              prom_we,
    output logic [sbk_mem_pkg::PROM_AW-1:0]   prom_addr,
    // ROM clients
    input  sbk_bus_pkg::slot_req_t            scr_req,
    input  sbk_bus_pkg::slot_req_t            snd_req,
    input  sbk_bus_pkg::slot_req_t            main_req,
    output logic [31:0]                       scr_dout,
    output logic [7:0]                        snd_dout,
    output logic [7:0]                        main_dout,
    output logic                              scr_ok,
    output logic                              snd_ok,
    output logic                              main_ok,
    // SDRAM
    output logic                              sdram_req,
    input  logic                              sdram_ack,
    output logic [sbk_mem_pkg::SDRAM_AW-1:0]  sdram_addr,
    input  sbk_bus_pkg::sdram_word_u          data_read,
    input  logic                              data_dst,
    input  logic                              data_rdy
);
    import sbk_mem_pkg::*;

    slot_e                 sel;
    logic                  start;
    logic                  byte_hi;
    logic [NUM_SLOTS-1:0]  hit;
    logic                  done;

    sbk_dwnld_decode #(
        .SCR_START  ( SCR_START  ),
        .PCM_START  ( PCM_START  ),
        .PROM_START ( PROM_START )
    ) decode_i (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog        ( prog        ),
        .prom_we     ( prom_we     ),
        .prom_addr   ( prom_addr   )
    );

    sbk_slot_arbiter #(
        .SND_START ( SND_START ),
        .SCR_START ( SCR_START )
    ) arbiter_i (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .scr_req     ( scr_req     ),
        .snd_req     ( snd_req     ),
        .main_req    ( main_req    ),
        .done        ( done        ),
        .sdram_ack   ( sdram_ack   ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sel         ( sel         ),
        .start       ( start       ),
        .byte_hi     ( byte_hi     ),
        .hit         ( hit         )
    );

    // Bit order of cs and ok follows slot_e
    sbk_slot_return return_i (
        .clk       ( clk                                     ),
        .reset     ( reset                                   ),
        .sel       ( sel                                     ),
        .start     ( start                                   ),
        .byte_hi   ( byte_hi                                 ),
        .hit       ( hit                                     ),
        .cs        ( {main_req.cs, snd_req.cs, scr_req.cs}   ),
        .data_read ( data_read                               ),
        .data_dst  ( data_dst                                ),
        .data_rdy  ( data_rdy                                ),
        .scr_dout  ( scr_dout                                ),
        .snd_dout  ( snd_dout                                ),
        .main_dout ( main_dout                               ),
        .ok        ( {main_ok, snd_ok, scr_ok}               ),
        .done      ( done                                    )
    );

endmodule

`default_nettype wire

// ==== test/sbk_rom_checker.sv ====
/*
 * Protocol assertions on the ROM subsystem ports, bound to sbk_rom_top.
 * Each failing assertion bumps fail_count, which the testbench watches.
 * Assumes the loader waits for sdram_ack before its next byte.
 */
`timescale 1ns/10ps
`default_nettype none

module sbk_rom_checker (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              downloading,
    input  logic                              sdram_req,
    input  logic                              sdram_ack,
    input  logic [sbk_mem_pkg::SDRAM_AW-1:0]  sdram_addr,
    input  sbk_bus_pkg::prog_wr_t             prog,
    input  logic                              prom_we,
    input  sbk_bus_pkg::slot_req_t            scr_req,
    input  sbk_bus_pkg::slot_req_t            snd_req,
    input  sbk_bus_pkg::slot_req_t            main_req,
    input  logic                              scr_ok,
    input  logic                              snd_ok,
    input  logic                              main_ok
);
    int fail_count = 0;

    // Read request and its address stay put until the ack
    req_held: assert property (@(posedge clk) disable iff (reset)
        sdram_req && !sdram_ack |=> sdram_req || downloading)
        else begin
            $error("sdram_req dropped before sdram_ack");
            fail_count++;
        end

    addr_held: assert property (@(posedge clk) disable iff (reset)
        sdram_req && !sdram_ack |=> $stable(sdram_addr) || downloading)
        else begin
            $error("sdram_addr changed during a pending request");
            fail_count++;
        end

    prog_held: assert property (@(posedge clk) disable iff (reset)
        prog.we && !sdram_ack |=> $stable(prog))
        else begin
            $error("prog changed before sdram_ack");
            fail_count++;
        end

    no_req_in_download: assert property (@(posedge clk) disable iff (reset)
        downloading |-> !sdram_req)
        else begin
            $error("sdram_req raised while downloading");
            fail_count++;
        end

    // An ok flag needs its client selected, and rises a cycle after cs
    scr_ok_cs: assert property (@(posedge clk) disable iff (reset)
        scr_ok |-> scr_req.cs && $past(scr_req.cs))
        else begin
            $error("scr_ok high without scr cs held for a cycle");
            fail_count++;
        end

    snd_ok_cs: assert property (@(posedge clk) disable iff (reset)
        snd_ok |-> snd_req.cs && $past(snd_req.cs))
        else begin
            $error("snd_ok high without snd cs held for a cycle");
            fail_count++;
        end

    main_ok_cs: assert property (@(posedge clk) disable iff (reset)
        main_ok |-> main_req.cs && $past(main_req.cs))
        else begin
            $error("main_ok high without main cs held for a cycle");
            fail_count++;
        end

    prom_vs_prog: assert property (@(posedge clk) disable iff (reset) !(prom_we && prog.we))
        else begin
            $error("prom_we and prog.we high together");
            fail_count++;
        end

endmodule

bind sbk_rom_top sbk_rom_checker checker_i (
    .clk         ( clk         ),
    .reset       ( reset       ),
    .downloading ( downloading ),
    .sdram_req   ( sdram_req   ),
    .sdram_ack   ( sdram_ack   ),
    .sdram_addr  ( sdram_addr  ),
    .prog        ( prog        ),
    .prom_we     ( prom_we     ),
    .scr_req     ( scr_req     ),
    .snd_req     ( snd_req     ),
    .main_req    ( main_req    ),
    .scr_ok      ( scr_ok      ),
    .snd_ok      ( snd_ok      ),
    .main_ok     ( main_ok     )
);

`default_nettype wire

// ==== test/sbk_rom_tb.sv ====
/*
 * Testbench for sbk_rom_top with a pattern SDRAM model.
 * Every SDRAM word reads as its word address XOR 16'h5a5a.
 * snd and scr slot addresses stay below 13 bits to remain in their regions.
 */
`timescale 1ns/10ps
`default_nettype none

`include "sbk_defaults.svh"

module sbk_rom_tb;
    import sbk_mem_pkg::*;
    import sbk_bus_pkg::*;

    localparam logic [IOCTL_AW-1:0] SND_START  = `SBK_SND_START;
    localparam logic [IOCTL_AW-1:0] SCR_START  = `SBK_SCR_START;
    localparam logic [IOCTL_AW-1:0] PCM_START  = `SBK_PCM_START;
    localparam logic [IOCTL_AW-1:0] PROM_START = `SBK_PROM_START;
    localparam logic [31:0]         SEED       = 32'h2e51a03b;
    localparam int                  WAIT_LIMIT = 100;

    logic                 clk;
    logic                 reset;
    logic                 downloading;
    logic [IOCTL_AW-1:0]  ioctl_addr;
    logic [7:0]           ioctl_dout;
    logic                 ioctl_wr;
    prog_wr_t             prog;
    logic                 prom_we;
    logic [PROM_AW-1:0]   prom_addr;
    slot_req_t            scr_req;
    slot_req_t            snd_req;
    slot_req_t            main_req;
    logic [31:0]          scr_dout;
    logic [7:0]           snd_dout;
    logic [7:0]           main_dout;
    logic                 scr_ok;
    logic                 snd_ok;
    logic                 main_ok;
    logic                 sdram_req;
    logic                 sdram_ack = 1'b0;
    logic [SDRAM_AW-1:0]  sdram_addr;
    sdram_word_u          data_read = '0;
    logic                 data_dst = 1'b0;
    logic                 data_rdy = 1'b0;
    logic [2:0]           ok_vec;
    logic [31:0]          rng;
    logic [15:0]          last_read [3];

    // SDRAM model state
    logic [31:0]          model_rng = SEED;
    int                   ack_wait = 0;
    int                   words_left = 0;
    int                   read_words = 0;
    logic [SDRAM_AW-1:0]  word_addr = '0;

    assign ok_vec = {main_ok, snd_ok, scr_ok};

    sbk_rom_top #(
        .SND_START  ( SND_START  ),
        .SCR_START  ( SCR_START  ),
        .PCM_START  ( PCM_START  ),
        .PROM_START ( PROM_START )
    ) dut_i (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] model_word(input logic [SDRAM_AW-1:0] w);
        return w[15:0] ^ 16'h5a5a;
    endfunction

    // First SDRAM word of a slot fetch
    function automatic logic [SDRAM_AW-1:0] expected_word(input int slot, input logic [15:0] a);
        case (slot)
            0:       return SDRAM_AW'(SCR_START >> 1) + SDRAM_AW'({a, 1'b0});
            1:       return SDRAM_AW'(SND_START >> 1) + SDRAM_AW'(a >> 1);
            default: return SDRAM_AW'(a >> 1);
        endcase
    endfunction

    function automatic logic [31:0] expected_data(input int slot, input logic [15:0] a);
        logic [SDRAM_AW-1:0] w;
        logic [15:0]         data_word;
        w = expected_word(slot, a);
        data_word = model_word(w);
        if (slot == 0) begin
            return {model_word(w + 1'b1), data_word};
        end
        return a[0] ? {24'd0, data_word[15:8]} : {24'd0, data_word[7:0]};
    endfunction

    function automatic logic [31:0] slot_dout(input int slot);
        case (slot)
            0:       return scr_dout;
            1:       return {24'd0, snd_dout};
            default: return {24'd0, main_dout};
        endcase
    endfunction

    function automatic string dout_name(input int slot);
        case (slot)
            0:       return "scr_dout";
            1:       return "snd_dout";
            default: return "main_dout";
        endcase
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic wait_ack();
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (sdram_ack) break;
        end
        if (!sdram_ack) begin
            $display("Timeout waiting for sdram_ack on a program write");
            abort_run();
        end
    endtask

    task automatic wait_req(input logic level);
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (sdram_req === level) break;
        end
        if (sdram_req !== level) begin
            $display("Timeout waiting for sdram_req to become %0d", level);
            abort_run();
        end
    endtask

    task automatic wait_ok(input logic [2:0] mask);
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if ((ok_vec & mask) == mask) break;
        end
        if ((ok_vec & mask) != mask) begin
            $display("Timeout waiting for ok flags %b, saw %b", mask, ok_vec);
            abort_run();
        end
    endtask

    task automatic drive_req(input int slot, input logic sel_cs, input logic [15:0] sel_addr);
        case (slot)
            0:       scr_req  = '{cs: sel_cs, addr: sel_addr};
            1:       snd_req  = '{cs: sel_cs, addr: sel_addr};
            default: main_req = '{cs: sel_cs, addr: sel_addr};
        endcase
    endtask

    task automatic download_byte(input logic [IOCTL_AW-1:0] addr, input logic [7:0] data);
        logic [7:0]          exp_data;
        logic [IOCTL_AW-1:0] prom_ofs;
        exp_data = data;
        if (addr >= SCR_START && addr < PCM_START) begin
            // Graphics bytes are stored nibble swapped
            exp_data = {data[3:0], data[7:4]};
        end
        prom_ofs   = addr - PROM_START;
        ioctl_addr = addr;
        ioctl_dout = data;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        if (addr >= PROM_START) begin
            check_value("prom_we", prom_we, 1);
            check_value("prom_addr", prom_addr, prom_ofs[PROM_AW-1:0]);
            check_value("prog.we", prog.we, 0);
            @(negedge clk);
            check_value("prom_we", prom_we, 0);
            check_value("prog.we", prog.we, 0);
        end else begin
            check_value("prog.we", prog.we, 1);
            check_value("prog.addr", prog.addr, 32'(addr >> 1));
            // Unused byte lane is masked
            check_value("prog.mask", prog.mask, addr[0] ? 2'b01 : 2'b10);
            check_value("prog.data", prog.data, exp_data);
            wait_ack();
            check_value("prog.we", prog.we, 0);
        end
    endtask

    task automatic read_slot(input int slot, input logic [15:0] addr);
        logic [31:0] exp;
        exp = expected_data(slot, addr);
        drive_req(slot, 1'b1, addr);
        wait_ok(3'b001 << slot);
        check_value(dout_name(slot), slot_dout(slot), exp);
        drive_req(slot, 1'b0, addr);
        last_read[slot] = addr;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // SDRAM model, random ack delay then one data_dst per word
    always @(negedge clk) begin
        sdram_ack <= 1'b0;
        data_dst  <= 1'b0;
        data_rdy  <= 1'b0;
        if (words_left > 0) begin
            data_read.half <= model_word(word_addr);
            data_dst       <= 1'b1;
            data_rdy       <= words_left == 1;
            word_addr  = word_addr + 1'b1;
            words_left = words_left - 1;
        end else if (ack_wait > 0) begin
            ack_wait = ack_wait - 1;
            if (ack_wait == 0) begin
                sdram_ack <= 1'b1;
                words_left = read_words;
            end
        end else if (!reset && (sdram_req || prog.we)) begin
            model_rng = lcg_step(model_rng);
            ack_wait  = 1 + model_rng[17:16];
            word_addr = sdram_addr;
            read_words = 0;
            if (sdram_req) begin
                // Scroll tile entries span two words
                read_words = (sdram_addr >= SDRAM_AW'(SCR_START >> 1) &&
                              sdram_addr < SDRAM_AW'(PCM_START >> 1)) ? 2 : 1;
            end
        end
    end

    always @(negedge clk) begin
        if (dut_i.checker_i.fail_count != 0) begin
            $display("A bound assertion on the DUT failed");
            abort_run();
        end
    end

    initial begin
        logic [15:0] miss_addr [3];
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        scr_req     = '0;
        snd_req     = '0;
        main_req    = '0;
        rng         = SEED;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // Download into main, scroll and PROM regions
        downloading = 1'b1;
        for (int i = 0; i < 4; i++) begin
            rng = lcg_step(rng);
            download_byte(IOCTL_AW'(rng[31:16]), rng[7:0]);
            rng = lcg_step(rng);
            download_byte(SCR_START + rng[31:16] % (PCM_START - SCR_START), rng[7:0]);
            rng = lcg_step(rng);
            download_byte(PROM_START + rng[26:16], rng[7:0]);
        end
        downloading = 1'b0;
        @(negedge clk);

        // Random single slot reads
        for (int i = 0; i < 6; i++) begin
            rng = lcg_step(rng);
            read_slot(1, {3'b000, rng[28:16]});
            rng = lcg_step(rng);
            read_slot(2, rng[31:16]);
        end
        for (int i = 0; i < 3; i++) begin
            rng = lcg_step(rng);
            read_slot(0, {3'b000, rng[28:16]});
        end

        // Three misses at once come out in priority order
        for (int s = 0; s < 3; s++) begin
            miss_addr[s] = last_read[s] ^ 16'h0004;
            drive_req(s, 1'b1, miss_addr[s]);
        end
        for (int s = 0; s < 3; s++) begin
            wait_req(1'b1);
            check_value("sdram_addr", sdram_addr, expected_word(s, miss_addr[s]));
            wait_req(1'b0);
        end
        wait_ok(3'b111);
        for (int s = 0; s < 3; s++) begin
            check_value(dout_name(s), slot_dout(s), expected_data(s, miss_addr[s]));
        end

        // Repeated addresses are served from the slot caches
        scr_req.cs  = 1'b0;
        snd_req.cs  = 1'b0;
        main_req.cs = 1'b0;
        @(negedge clk);
        check_value("ok", ok_vec, 3'b000);
        scr_req.cs  = 1'b1;
        snd_req.cs  = 1'b1;
        main_req.cs = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("ok", ok_vec, 3'b111);
            check_value("sdram_req", sdram_req, 0);
        end

        // A new download hides every slot
        downloading = 1'b1;
        @(negedge clk);
        check_value("ok", ok_vec, 3'b000);
        check_value("sdram_req", sdram_req, 0);
        downloading = 1'b0;
        scr_req     = '0;
        snd_req     = '0;
        main_req    = '0;
        repeat (2) @(negedge clk);

        if (dut_i.checker_i.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Bound assertions reported failures");
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
design/sbk_mem_pkg.sv
design/sbk_bus_pkg.sv
design/sbk_dwnld_decode.sv
design/sbk_slot_arbiter.sv
design/sbk_slot_return.sv
design/sbk_rom_top.sv
test/sbk_rom_checker.sv
test/sbk_rom_tb.sv

// ==== Bender.yml ====
package:
  name: sbk_rom

sources:
  - include_dirs:
      - include
    files:
      - design/sbk_mem_pkg.sv
      - design/sbk_bus_pkg.sv
      - design/sbk_dwnld_decode.sv
      - design/sbk_slot_arbiter.sv
      - design/sbk_slot_return.sv
      - design/sbk_rom_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/sbk_rom_checker.sv
      - test/sbk_rom_tb.sv
